// ==== logic/fabric_params.svh ====
`ifndef FABRIC_PARAMS_SVH
`define FABRIC_PARAMS_SVH

// bus widths
`define FABRIC_ADDR_W 32
`define FABRIC_DATA_W 32
`define FABRIC_ID_W 4

// requesters sharing the read channel
`define FABRIC_N_PORTS 2

// clint window, 64 KB
`define FABRIC_CLINT_BASE 32'h0200_0000
`define FABRIC_CLINT_SIZE 32'h0001_0000

// mtime halves inside the window
`define FABRIC_MTIME_LO_OFF 16'hbff8
`define FABRIC_MTIME_HI_OFF 16'hbffc

`endif

// ==== logic/axi_pkg.sv ====
package axi_pkg;

  // read response codes, axi encoding
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_t;

endpackage

// ==== logic/fabric_pkg.sv ====
package fabric_pkg;

  // arbiter sequencer
  typedef enum logic [1:0] {
    arb_idle = 2'd0,
    arb_addr = 2'd1, // address phase on shared channel
    arb_data = 2'd2  // waiting for the single read beat
  } arb_state_t;

  // where a read is routed
  typedef enum logic {
    tgt_mem   = 1'b0,
    tgt_clint = 1'b1
  } target_t;

  // timer register select
  typedef enum logic [1:0] {
    reg_mtime_lo = 2'd0,
    reg_mtime_hi = 2'd1,
    reg_none     = 2'd2 // unmapped offset
  } clint_reg_t;

endpackage

// ==== logic/read_port.sv ====
`include "fabric_params.svh"

module read_port import axi_pkg::*; (
  input  logic                      clock,
  input  logic                      rst,
  // requester request channel
  input  logic                      req_valid,
  output logic                      req_ready,
  input  logic [`FABRIC_ADDR_W-1:0] req_addr,
  input  logic [`FABRIC_ID_W-1:0]   req_id,
  // requester response channel
  output logic                      rsp_valid,
  input  logic                      rsp_ready,
  output logic [`FABRIC_DATA_W-1:0] rsp_data,
  output axi_resp_t                 rsp_resp,
  output logic [`FABRIC_ID_W-1:0]   rsp_id,
  // towards the arbiter
  output logic                      pend,
  output logic [`FABRIC_ADDR_W-1:0] pend_addr,
  input  logic                      done,
  input  logic [`FABRIC_DATA_W-1:0] done_data,
  input  axi_resp_t                 done_resp
);

  logic                      pend_q;
  logic                      rsp_valid_q;
  logic [`FABRIC_ADDR_W-1:0] addr_q;
  logic [`FABRIC_ID_W-1:0]   id_q;    // echoed back with the response
  logic [`FABRIC_DATA_W-1:0] data_q;
  axi_resp_t                 resp_q;

  // one transaction per port, request or response
  assign req_ready = !pend_q && !rsp_valid_q;

  always_ff @(posedge clock) begin
    if (rst) begin
      pend_q      <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (req_valid && req_ready) begin
        pend_q <= 1'b1;
      end else if (done) begin
        pend_q      <= 1'b0;
        rsp_valid_q <= 1'b1; // response parked here
      end else if (rsp_valid_q && rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid && req_ready) begin
      addr_q <= req_addr;
      id_q   <= req_id;
    end
    if (done) begin
      data_q <= done_data;
      resp_q <= done_resp;
    end
  end

  assign pend      = pend_q;
  assign pend_addr = addr_q;
  assign rsp_valid = rsp_valid_q;
  assign rsp_data  = data_q;
  assign rsp_resp  = resp_q;
  assign rsp_id    = id_q;

endmodule

// ==== logic/read_arbiter.sv ====
`include "fabric_params.svh"

module read_arbiter import axi_pkg::*, fabric_pkg::*; (
  input  logic                      clock,
  input  logic                      rst,
  // read ports
  input  logic [`FABRIC_N_PORTS-1:0] pend,
  input  logic [`FABRIC_ADDR_W-1:0]  pend_addr [`FABRIC_N_PORTS],
  output logic [`FABRIC_N_PORTS-1:0] done,
  output logic [`FABRIC_DATA_W-1:0]  done_data,
  output axi_resp_t                  done_resp,
  // shared read channel
  output logic                       ar_valid,
  input  logic                       ar_ready,
  output logic [`FABRIC_ADDR_W-1:0]  ar_addr,
  input  logic                       r_valid,
  output logic                       r_ready,
  input  logic [`FABRIC_DATA_W-1:0]  r_data,
  input  axi_resp_t                  r_resp
);

  localparam int IDX_W = (`FABRIC_N_PORTS > 1) ? $clog2(`FABRIC_N_PORTS) : 1;

  arb_state_t       state;
  logic [IDX_W-1:0] last_q;  // round-robin pointer, last served port
  logic [IDX_W-1:0] gnt_q;   // port owning the channel
  logic [IDX_W-1:0] pick;
  logic [IDX_W-1:0] cand;
  logic             found;

  // search starts one past the last served port
  always_comb begin
    pick  = last_q;
    found = 1'b0;
    cand  = last_q;
    for (int i = 1; i <= `FABRIC_N_PORTS; i++) begin
      cand = IDX_W'((int'(last_q) + i) % `FABRIC_N_PORTS);
      if (!found && pend[cand]) begin
        pick  = cand;
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state  <= arb_idle;
      gnt_q  <= '0;
      last_q <= IDX_W'(`FABRIC_N_PORTS - 1); // port 0 first out of reset
    end else begin
      case (state)
        arb_idle: begin
          if (found) begin
            gnt_q <= pick;
            state <= arb_addr;
          end
        end
        arb_addr: if (ar_ready) state <= arb_data;
        arb_data: begin
          if (r_valid) begin
            last_q <= gnt_q;
            state  <= arb_idle;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

  // port holds its address stable while pend is high
  assign ar_valid = (state == arb_addr);
  assign ar_addr  = pend_addr[gnt_q];
  assign r_ready  = (state == arb_data);

  // done pulse in the beat cycle, so pend is gone before the next grant
  always_comb begin
    done = '0;
    if (state == arb_data && r_valid) begin
      done[gnt_q] = 1'b1;
    end
  end

  assign done_data = r_data;
  assign done_resp = r_resp;

endmodule

// ==== logic/addr_router.sv ====
`include "fabric_params.svh"

module addr_router import axi_pkg::*, fabric_pkg::*; (
  input  logic                      clock,
  input  logic                      rst,
  // shared channel from the arbiter
  input  logic                      ar_valid,
  output logic                      ar_ready,
  input  logic [`FABRIC_ADDR_W-1:0] ar_addr,
  output logic                      r_valid,
  input  logic                      r_ready,
  output logic [`FABRIC_DATA_W-1:0] r_data,
  output axi_resp_t                 r_resp,
  // timer
  output logic                      t_ar_valid,
  input  logic                      t_ar_ready,
  output logic [15:0]               t_ar_off,
  input  logic                      t_r_valid,
  output logic                      t_r_ready,
  input  logic [`FABRIC_DATA_W-1:0] t_r_data,
  input  axi_resp_t                 t_r_resp,
  // external memory
  output logic                      mem_ar_valid,
  input  logic                      mem_ar_ready,
  output logic [`FABRIC_ADDR_W-1:0] mem_ar_addr,
  input  logic                      mem_r_valid,
  output logic                      mem_r_ready,
  input  logic [`FABRIC_DATA_W-1:0] mem_r_data,
  input  axi_resp_t                 mem_r_resp
);

  target_t tgt;
  target_t tgt_q; // target of the outstanding read

  assign tgt = (ar_addr >= `FABRIC_CLINT_BASE &&
                ar_addr <  `FABRIC_CLINT_BASE + `FABRIC_CLINT_SIZE) ? tgt_clint : tgt_mem;

  // address side is pure decode
  assign t_ar_valid   = ar_valid && (tgt == tgt_clint);
  assign t_ar_off     = ar_addr[15:0];
  assign mem_ar_valid = ar_valid && (tgt == tgt_mem);
  assign mem_ar_addr  = ar_addr;
  assign ar_ready     = (tgt == tgt_clint) ? t_ar_ready : mem_ar_ready;

  always_ff @(posedge clock) begin
    if (rst) begin
      tgt_q <= tgt_mem;
    end else if (ar_valid && ar_ready) begin
      tgt_q <= tgt;
    end
  end

  // response steered by the latched target
  assign t_r_ready   = r_ready && (tgt_q == tgt_clint);
  assign mem_r_ready = r_ready && (tgt_q == tgt_mem);
  assign r_valid     = (tgt_q == tgt_clint) ? t_r_valid : mem_r_valid;
  assign r_data      = (tgt_q == tgt_clint) ? t_r_data  : mem_r_data;
  assign r_resp      = (tgt_q == tgt_clint) ? t_r_resp  : mem_r_resp;

endmodule

// ==== logic/clint_timer.sv ====
`include "fabric_params.svh"

module clint_timer import axi_pkg::*, fabric_pkg::*; (
  input  logic                      clock,
  input  logic                      rst,
  input  logic                      t_ar_valid,
  output logic                      t_ar_ready,
  input  logic [15:0]               t_ar_off,
  output logic                      t_r_valid,
  input  logic                      t_r_ready,
  output logic [`FABRIC_DATA_W-1:0] t_r_data,
  output axi_resp_t                 t_r_resp
);

  logic [63:0] mtime;
  logic        r_valid_q;
  clint_reg_t  sel;

  always_comb begin
    case (t_ar_off)
      `FABRIC_MTIME_LO_OFF: sel = reg_mtime_lo;
      `FABRIC_MTIME_HI_OFF: sel = reg_mtime_hi;
      default:              sel = reg_none;
    endcase
  end

  // free running, one tick per clock
  always_ff @(posedge clock) begin
    if (rst) mtime <= '0;
    else     mtime <= mtime + 64'd1;
  end

  assign t_ar_ready = !r_valid_q; // single response slot

  always_ff @(posedge clock) begin
    if (rst) begin
      r_valid_q <= 1'b0;
    end else if (t_ar_valid && t_ar_ready) begin
      r_valid_q <= 1'b1;
    end else if (t_r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  // value sampled at the address transfer
  always_ff @(posedge clock) begin
    if (t_ar_valid && t_ar_ready) begin
      case (sel)
        reg_mtime_lo: t_r_data <= mtime[31:0];
        reg_mtime_hi: t_r_data <= mtime[63:32];
        default:      t_r_data <= '0;
      endcase
      t_r_resp <= (sel == reg_none) ? resp_slverr : resp_okay;
    end
  end

  assign t_r_valid = r_valid_q;

endmodule

// ==== logic/read_fabric.sv ====
`include "fabric_params.svh"

module read_fabric import axi_pkg::*; (
  input  logic                       clock,
  input  logic                       rst,
  // requester side, one entry per port
  input  logic [`FABRIC_N_PORTS-1:0] req_valid,
  output logic [`FABRIC_N_PORTS-1:0] req_ready,
  input  logic [`FABRIC_ADDR_W-1:0]  req_addr [`FABRIC_N_PORTS],
  input  logic [`FABRIC_ID_W-1:0]    req_id   [`FABRIC_N_PORTS],
  output logic [`FABRIC_N_PORTS-1:0] rsp_valid,
  input  logic [`FABRIC_N_PORTS-1:0] rsp_ready,
  output logic [`FABRIC_DATA_W-1:0]  rsp_data [`FABRIC_N_PORTS],
  output axi_resp_t                  rsp_resp [`FABRIC_N_PORTS],
  output logic [`FABRIC_ID_W-1:0]    rsp_id   [`FABRIC_N_PORTS],
  // external memory
  output logic                       mem_ar_valid,
  input  logic                       mem_ar_ready,
  output logic [`FABRIC_ADDR_W-1:0]  mem_ar_addr,
  input  logic                       mem_r_valid,
  output logic                       mem_r_ready,
  input  logic [`FABRIC_DATA_W-1:0]  mem_r_data,
  input  axi_resp_t                  mem_r_resp
);

  logic [`FABRIC_N_PORTS-1:0] pend;
  logic [`FABRIC_ADDR_W-1:0]  pend_addr [`FABRIC_N_PORTS];
  logic [`FABRIC_N_PORTS-1:0] done;
  logic [`FABRIC_DATA_W-1:0]  done_data;
  axi_resp_t                  done_resp;

  // shared channel, arbiter to router
  logic                      ar_valid;
  logic                      ar_ready;
  logic [`FABRIC_ADDR_W-1:0] ar_addr;
  logic                      r_valid;
  logic                      r_ready;
  logic [`FABRIC_DATA_W-1:0] r_data;
  axi_resp_t                 r_resp;

  // router to timer
  logic                      t_ar_valid;
  logic                      t_ar_ready;
  logic [15:0]               t_ar_off;
  logic                      t_r_valid;
  logic                      t_r_ready;
  logic [`FABRIC_DATA_W-1:0] t_r_data;
  axi_resp_t                 t_r_resp;

  for (genvar p = 0; p < `FABRIC_N_PORTS; p++) begin : g_port
    read_port port_i (
      .clock     (clock),
      .rst       (rst),
      .req_valid (req_valid[p]),
      .req_ready (req_ready[p]),
      .req_addr  (req_addr[p]),
      .req_id    (req_id[p]),
      .rsp_valid (rsp_valid[p]),
      .rsp_ready (rsp_ready[p]),
      .rsp_data  (rsp_data[p]),
      .rsp_resp  (rsp_resp[p]),
      .rsp_id    (rsp_id[p]),
      .pend      (pend[p]),
      .pend_addr (pend_addr[p]),
      .done      (done[p]),
      .done_data (done_data), // broadcast, qualified by done
      .done_resp (done_resp)
    );
  end

  read_arbiter arb_i (
    .clock     (clock),
    .rst       (rst),
    .pend      (pend),
    .pend_addr (pend_addr),
    .done      (done),
    .done_data (done_data),
    .done_resp (done_resp),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar_addr   (ar_addr),
    .r_valid   (r_valid),
    .r_ready   (r_ready),
    .r_data    (r_data),
    .r_resp    (r_resp)
  );

  addr_router router_i (
    .clock        (clock),
    .rst          (rst),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar_addr      (ar_addr),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .r_data       (r_data),
    .r_resp       (r_resp),
    .t_ar_valid   (t_ar_valid),
    .t_ar_ready   (t_ar_ready),
    .t_ar_off     (t_ar_off),
    .t_r_valid    (t_r_valid),
    .t_r_ready    (t_r_ready),
    .t_r_data     (t_r_data),
    .t_r_resp     (t_r_resp),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar_ready (mem_ar_ready),
    .mem_ar_addr  (mem_ar_addr),
    .mem_r_valid  (mem_r_valid),
    .mem_r_ready  (mem_r_ready),
    .mem_r_data   (mem_r_data),
    .mem_r_resp   (mem_r_resp)
  );

  clint_timer timer_i (
    .clock      (clock),
    .rst        (rst),
    .t_ar_valid (t_ar_valid),
    .t_ar_ready (t_ar_ready),
    .t_ar_off   (t_ar_off),
    .t_r_valid  (t_r_valid),
    .t_r_ready  (t_r_ready),
    .t_r_data   (t_r_data),
    .t_r_resp   (t_r_resp)
  );

endmodule

// ==== test/ext_mem_model.sv ====
module ext_mem_model import axi_pkg::*; (
  input  logic        clock,
  input  logic        rst,
  input  logic        ar_stall, // stall requests from the testbench
  input  logic        r_stall,
  input  logic        mem_ar_valid,
  output logic        mem_ar_ready,
  input  logic [31:0] mem_ar_addr,
  output logic        mem_r_valid,
  input  logic        mem_r_ready,
  output logic [31:0] mem_r_data,
  output axi_resp_t   mem_r_resp
);

  logic        busy;
  logic        ar_fire;
  logic        r_fire;
  logic        ar_hold;
  logic        r_hold;
  logic [31:0] addr_q;

  initial begin
    busy         = 1'b0;
    mem_ar_ready = 1'b0;
    mem_r_valid  = 1'b0;
    mem_r_data   = '0;
    mem_r_resp   = resp_okay;
  end

  // transfers and stall requests seen at the rising edge
  always @(posedge clock) begin
    ar_fire <= mem_ar_valid && mem_ar_ready;
    r_fire  <= mem_r_valid && mem_r_ready;
    ar_hold <= ar_stall;
    r_hold  <= r_stall;
    if (mem_ar_valid && mem_ar_ready) addr_q <= mem_ar_addr;
  end

  // outputs change on the falling edge
  always @(negedge clock) begin
    if (rst) begin
      busy         <= 1'b0;
      mem_ar_ready <= 1'b0;
      mem_r_valid  <= 1'b0;
    end else begin
      if (r_fire) begin
        busy        <= 1'b0;
        mem_r_valid <= 1'b0;
      end else if (ar_fire) begin
        busy <= 1'b1;
      end else if (busy && !mem_r_valid && !r_hold) begin
        mem_r_valid <= 1'b1;
        mem_r_data  <= addr_q ^ 32'ha5a5_0000; // memory contents
        mem_r_resp  <= resp_okay;
      end
      mem_ar_ready <= !busy && !ar_fire && !ar_hold; // one read at a time
    end
  end

endmodule

// ==== test/read_fabric_tb.sv ====
`include "fabric_params.svh"

module read_fabric_tb import axi_pkg::*; ();

  localparam int N_RAND      = 40;
  localparam int N_ALT       = 12;
  localparam int MAX_STALL   = 4;
  localparam int N_TXN       = 2 + 2 * N_RAND + 8 + 2 * N_ALT;
  localparam int CYCLE_LIMIT = (N_TXN + 20) * (3 * MAX_STALL + 8);

  typedef struct packed {
    logic [`FABRIC_ADDR_W-1:0] addr;
    logic [`FABRIC_ID_W-1:0]   id;
  } item_t;

  logic                       clock = 1'b0;
  logic                       rst = 1'b1;
  logic [`FABRIC_N_PORTS-1:0] req_valid = '0;
  logic [`FABRIC_N_PORTS-1:0] req_ready;
  logic [`FABRIC_ADDR_W-1:0]  req_addr [`FABRIC_N_PORTS] = '{32'h0, 32'h0};
  logic [`FABRIC_ID_W-1:0]    req_id [`FABRIC_N_PORTS] = '{4'h0, 4'h0};
  logic [`FABRIC_N_PORTS-1:0] rsp_valid;
  logic [`FABRIC_N_PORTS-1:0] rsp_ready = '0;
  logic [`FABRIC_DATA_W-1:0]  rsp_data [`FABRIC_N_PORTS];
  axi_resp_t                  rsp_resp [`FABRIC_N_PORTS];
  logic [`FABRIC_ID_W-1:0]    rsp_id [`FABRIC_N_PORTS];
  logic                       mem_ar_valid;
  logic                       mem_ar_ready;
  logic [`FABRIC_ADDR_W-1:0]  mem_ar_addr;
  logic                       mem_r_valid;
  logic                       mem_r_ready;
  logic [`FABRIC_DATA_W-1:0]  mem_r_data;
  axi_resp_t                  mem_r_resp;
  logic                       ar_stall = 1'b0;
  logic                       r_stall = 1'b0;

  item_t       exp_q0 [$]; // expected items in request order
  item_t       exp_q1 [$];
  bit          mem_log [$]; // port behind each accepted memory address
  logic [31:0] rnd_env = 32'h5171;
  logic [31:0] rnd_port [2];
  logic [31:0] last_mtime = '0;
  int          stall_run = 0;
  int          cycles = 0;
  bit          rready_rand = 1'b0;
  bit          log_alt = 1'b0;

  always #2 clock = ~clock;

  read_fabric dut_i (.*);

  ext_mem_model mem_i (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic bit in_clint(input logic [31:0] addr);
    return addr >= `FABRIC_CLINT_BASE && addr < `FABRIC_CLINT_BASE + `FABRIC_CLINT_SIZE;
  endfunction

  // returns resp above data
  function automatic logic [33:0] ref_read(input logic [31:0] addr);
    if (!in_clint(addr)) return {resp_okay, addr ^ 32'ha5a5_0000};
    if (addr[15:0] == `FABRIC_MTIME_LO_OFF || addr[15:0] == `FABRIC_MTIME_HI_OFF)
      return {resp_okay, 32'h0}; // high half still zero in a short run
    return {resp_slverr, 32'h0};
  endfunction

  // port 0 below 1000_0000 and clear of the clint window
  function automatic logic [31:0] mem_addr_for(input int p, input logic [31:0] r);
    if (p == 0) return 32'h0800_0000 | (r & 32'h07ff_fffc);
    return 32'h1000_0000 | (r & 32'h7fff_fffc);
  endfunction

  function automatic int pending_count(input int p);
    return (p == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h", name, got, want);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic compare_rsp(input int p);
    item_t       it;
    logic [33:0] want;
    if (p == 0) it = exp_q0.pop_front();
    else        it = exp_q1.pop_front();
    want = ref_read(it.addr);
    check($sformatf("rsp_id[%0d]", p), rsp_id[p], it.id);
    check($sformatf("rsp_resp[%0d]", p), rsp_resp[p], want[33:32]);
    if (it.addr == `FABRIC_CLINT_BASE + `FABRIC_MTIME_LO_OFF) begin
      // only the order of free-running timer values is known
      check("rsp_data mtime_lo rising", rsp_data[p] > last_mtime, 1'b1);
      last_mtime = rsp_data[p];
    end else begin
      check($sformatf("rsp_data[%0d]", p), rsp_data[p], want[31:0]);
    end
  endtask

  // starts and ends on a falling edge
  task automatic send_req(input int p, input logic [31:0] addr, input logic [3:0] id);
    req_valid[p] = 1'b1;
    req_addr[p]  = addr;
    req_id[p]    = id;
    do @(posedge clock); while (!req_ready[p]);
    @(negedge clock);
    req_valid[p] = 1'b0;
  endtask

  task automatic run_port(input int p, input int count);
    for (int i = 0; i < count; i++) begin
      rnd_port[p] = xorshift(rnd_port[p]);
      send_req(p, mem_addr_for(p, rnd_port[p]), rnd_port[p][31:28]);
    end
  endtask

  task automatic wait_drain();
    do @(negedge clock); while (exp_q0.size() != 0 || exp_q1.size() != 0);
  endtask

  // stalls and back-pressure for at most MAX_STALL cycles in a row
  always @(negedge clock) begin
    rnd_env = xorshift(rnd_env);
    if (stall_run >= MAX_STALL) begin
      ar_stall  = 1'b0;
      r_stall   = 1'b0;
      rsp_ready = 2'b11;
      stall_run = 0;
    end else begin
      ar_stall  = rnd_env[0];
      r_stall   = rnd_env[1];
      rsp_ready = rready_rand ? rnd_env[3:2] : 2'b11;
      stall_run = (ar_stall || r_stall || rsp_ready != 2'b11) ? stall_run + 1 : 0;
    end
  end

  // scoreboard
  always @(posedge clock) begin
    if (!rst) begin
      for (int p = 0; p < `FABRIC_N_PORTS; p++) begin
        if (req_valid[p] && req_ready[p]) begin
          if (p == 0) exp_q0.push_back({req_addr[p], req_id[p]});
          else        exp_q1.push_back({req_addr[p], req_id[p]});
        end
        if (rsp_valid[p] && rsp_ready[p]) begin
          if (pending_count(p) == 0)
            abort_run($sformatf("port %0d returned a response that was never requested", p));
          else
            compare_rsp(p);
        end
      end
      if (mem_ar_valid && in_clint(mem_ar_addr))
        abort_run($sformatf("clint address %h showed up on the memory channel", mem_ar_addr));
      if (mem_ar_valid && mem_ar_ready && log_alt)
        mem_log.push_back(mem_ar_addr >= 32'h1000_0000);
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
      abort_run($sformatf("timeout after %0d cycles, the fabric stopped answering", cycles));
  end

  initial begin
    rnd_port[0] = xorshift(32'h5171 ^ 32'h9e37_79b9);
    rnd_port[1] = xorshift(32'h5171 ^ 32'h7f4a_7c15);
    repeat (2) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    repeat (4) begin // idle fabric after reset
      @(negedge clock);
      check("rsp_valid", rsp_valid, 2'b00);
      check("mem_ar_valid", mem_ar_valid, 1'b0);
      check("req_ready", req_ready, 2'b11);
    end
    send_req(0, 32'h0000_1230, 4'h3);
    wait_drain();
    send_req(1, 32'h1234_5678, 4'hc);
    wait_drain();
    rready_rand = 1'b1; // random traffic on both ports
    fork
      run_port(0, N_RAND);
      run_port(1, N_RAND);
    join
    wait_drain();
    rready_rand = 1'b0;
    for (int i = 0; i < 4; i++) begin
      send_req(0, `FABRIC_CLINT_BASE + `FABRIC_MTIME_LO_OFF, 4'(i));
      wait_drain();
    end
    for (int i = 0; i < 2; i++) begin
      send_req(0, `FABRIC_CLINT_BASE + `FABRIC_MTIME_HI_OFF, 4'(i + 8));
      wait_drain();
    end
    send_req(0, `FABRIC_CLINT_BASE, 4'h5); // unmapped offsets
    wait_drain();
    send_req(0, `FABRIC_CLINT_BASE + 32'h4000, 4'h6);
    wait_drain();
    log_alt = 1'b1; // both ports saturated
    fork
      run_port(0, N_ALT);
      run_port(1, N_ALT);
    join
    wait_drain();
    log_alt = 1'b0;
    check("mem_ar accepted count", mem_log.size(), 2 * N_ALT);
    // both ports pend together here and round robin resumes after port 0
    check("mem_ar_addr first port", mem_log[0], 1'b1);
    for (int i = 1; i < mem_log.size(); i++)
      check("mem_ar_addr port", mem_log[i], !mem_log[i-1]);
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+logic
logic/axi_pkg.sv
logic/fabric_pkg.sv
logic/read_port.sv
logic/read_arbiter.sv
logic/addr_router.sv
logic/clint_timer.sv
logic/read_fabric.sv
test/ext_mem_model.sv
test/read_fabric_tb.sv
